/* design/apbKeyPort.sv */
`timescale 1ns/1ps

module apbKeyPort #(
	parameter int boardWidth  = 10,
	parameter int boardHeight = 20
) (
	input  logic                   count,
	input  logic                   reset,
	input  tetrisPkg::apbReq       req,
	input  logic                   busyDone,
	input  logic                   gameOver,
	input  logic [15:0]            linesCleared,
	input  tetrisPkg::pieceState   activePiece,
	input  logic [boardWidth-1:0]  rowView,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output tetrisPkg::rowIndex     rowSelect,
	output tetrisPkg::moveRequest  request
);
	import tetrisPkg::*;

	logic       busy;
	logic       access;
	logic       cmdWrite;
	logic       cmdKnown;
	logic       accept;
	logic       isRow;
	logic [7:0] rowOffset;
	cmdCode     cmd;

	assign access   = req.psel && req.penable;
	assign cmdWrite = access && req.pwrite && (req.paddr == regCommand);
	assign cmd      = cmdCode'(req.pwdata[2:0]);
	assign cmdKnown = (req.pwdata != 32'd0) && (req.pwdata <= 32'd4);
	assign accept   = cmdWrite && !busy && cmdKnown; // unknown codes complete as no-ops

	// Back-pressure only on command writes
	assign pready  = !(cmdWrite && busy);
	assign pslverr = access && req.pwrite && (req.paddr != regCommand);

	assign rowOffset = req.paddr - regRowBase;
	assign isRow     = (req.paddr >= regRowBase) && (rowOffset[1:0] == 2'd0) &&
		(rowOffset[7:2] < boardHeight);
	assign rowSelect = rowOffset[6:2];

	always_comb begin
		prdata = '0;
		if (req.paddr == regStatus)
			prdata = {linesCleared, 9'd0, activePiece.shape, 2'd0, gameOver, busy};
		else if (isRow)
			prdata[boardWidth-1:0] = rowView;
	end

	// Candidate position, one step from the current piece
	always_comb begin
		request.valid     = accept;
		request.cmd       = cmd;
		request.current   = activePiece;
		request.candidate = activePiece;
		case (cmd)
			cmdLeft:    request.candidate.col = activePiece.col - 4'd1; // wraps, caught as off-board
			cmdRight:   request.candidate.col = activePiece.col + 4'd1;
			cmdDrop:    request.candidate.row = activePiece.row + 5'd1;
			cmdRestart: request.candidate = '0;
			default: ;
		endcase
	end

	always_ff @(posedge count) begin
		if (reset)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (busyDone)
			busy <= 1'b0;
	end

	penableAfterSetup: assert property (@(posedge count) disable iff (reset)
		$rose(req.penable) |-> $past(req.psel && !req.penable))
		else $error("penable raised without a setup cycle");

endmodule

/* design/boardUpdate.sv */
`timescale 1ns/1ps

module boardUpdate #(
	parameter int boardWidth  = 10,
	parameter int boardHeight = 20
) (
	input  logic                                   count,
	input  logic                                   reset,
	input  tetrisPkg::moveResult                   result,
	input  tetrisPkg::rowIndex                     rowSelect,
	output logic [boardHeight-1:0][boardWidth-1:0] settledRows,
	output tetrisPkg::pieceState                   activePiece,
	output logic [boardWidth-1:0]                  rowView,
	output logic                                   busyDone,
	output logic                                   gameOver,
	output logic [15:0]                            linesCleared
);
	import tetrisPkg::*;

	localparam colIndex spawnCol = colIndex'(boardWidth / 2 - 1);

	typedef logic [boardHeight-1:0][boardWidth-1:0] boardBits;
	typedef enum logic [1:0] {idle, clear, checkTop, spawn} stateType;

	stateType  state;
	shapeId    spawnIdx;
	shapeId    nextIdx;
	rowIndex   scanRow;
	pieceState spawnPiece;
	boardBits  activeBoard;
	boardBits  spawnBoard;
	logic      spawnHit;
	logic      rowFull;

	// Board image of one piece
	function automatic boardBits pieceMask(pieceState p);
		shapeOffsets offsets;
		boardBits    mask;
		int          r;
		int          c;
		offsets = shapeCells(p.shape);
		mask = '0;
		for (int i = 0; i < 4; i++) begin
			r = int'(p.row) + int'(offsets[i].dRow);
			c = int'(p.col) + int'(offsets[i].dCol);
			if (r < boardHeight && c < boardWidth)
				mask[r][c] = 1'b1;
		end
		return mask;
	endfunction

	assign spawnPiece  = '{shape: spawnIdx, row: '0, col: spawnCol};
	assign activeBoard = pieceMask(activePiece);
	assign spawnBoard  = pieceMask(spawnPiece);
	assign spawnHit    = |(spawnBoard & settledRows); // no room for the next piece
	assign nextIdx     = (spawnIdx == lastShape) ? 3'd0 : spawnIdx + 3'd1;
	assign rowFull     = &settledRows[scanRow];

	always_comb begin
		rowView = '0;
		if (rowSelect < boardHeight)
			rowView = settledRows[rowSelect] | activeBoard[rowSelect];
	end

	always_ff @(posedge count) begin
		if (reset) begin
			settledRows  <= '0;
			activePiece  <= '{shape: '0, row: '0, col: spawnCol};
			spawnIdx     <= 3'd1;
			scanRow      <= '0;
			state        <= idle;
			busyDone     <= 1'b0;
			gameOver     <= 1'b0;
			linesCleared <= '0;
		end else begin
			busyDone <= 1'b0;
			case (state)
				idle: if (result.valid) begin
					if (result.cmd == cmdRestart) begin
						settledRows  <= '0;
						gameOver     <= 1'b0;
						linesCleared <= '0;
						spawnIdx     <= 3'd0; // fresh cycle from the first shape
						state        <= spawn;
					end else if (gameOver) begin
						busyDone <= 1'b1;
					end else if (!result.blocked) begin
						activePiece <= result.piece;
						busyDone    <= 1'b1;
					end else if (result.cmd == cmdDrop) begin
						// Lock in place, then scan from the bottom
						settledRows <= settledRows | activeBoard;
						scanRow     <= rowIndex'(boardHeight - 1);
						state       <= clear;
					end else begin
						busyDone <= 1'b1;
					end
				end
				clear: begin
					if (rowFull) begin
						for (int r = boardHeight - 1; r > 0; r--)
							if (r <= scanRow)
								settledRows[r] <= settledRows[r-1];
						settledRows[0] <= '0;
						linesCleared   <= linesCleared + 16'd1; // same row rechecked next cycle
					end else if (scanRow == '0) begin
						state <= checkTop;
					end else begin
						scanRow <= scanRow - 5'd1;
					end
				end
				checkTop: begin
					if ((|settledRows[0]) || spawnHit) begin
						gameOver <= 1'b1;
						busyDone <= 1'b1;
						state    <= idle;
					end else begin
						state <= spawn;
					end
				end
				spawn: begin
					activePiece <= spawnPiece;
					spawnIdx    <= nextIdx;
					busyDone    <= 1'b1;
					state       <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	noOverlapInIdle: assert property (@(posedge count) disable iff (reset)
		(state == idle && !gameOver) |-> ((settledRows & activeBoard) == '0))
		else $error("active piece overlaps settled cells");

endmodule

/* design/moveCheck.sv */
`timescale 1ns/1ps

module moveCheck #(
	parameter int boardWidth  = 10,
	parameter int boardHeight = 20
) (
	input  logic                                   count,
	input  logic                                   reset,
	input  tetrisPkg::moveRequest                  request,
	input  logic [boardHeight-1:0][boardWidth-1:0] settledRows,
	output tetrisPkg::moveResult                   result
);
	import tetrisPkg::*;

	shapeOffsets     offsets;
	logic [3:0][5:0] cellRow; // one spare bit past the bottom
	logic [3:0][4:0] cellCol;
	logic [3:0]      cellHit;
	logic            blocked;

	assign offsets = shapeCells(request.candidate.shape);

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			cellRow[i] = {1'b0, request.candidate.row} + {4'd0, offsets[i].dRow};
			cellCol[i] = {1'b0, request.candidate.col} + {3'd0, offsets[i].dCol};
			// Off the side or below the floor
			if (cellCol[i] >= boardWidth || cellRow[i] >= boardHeight)
				cellHit[i] = 1'b1;
			else
				cellHit[i] = settledRows[rowIndex'(cellRow[i])][colIndex'(cellCol[i])];
		end
	end

	// Restart carries no position to test
	assign blocked = (request.cmd != cmdRestart) && (|cellHit);

	always_ff @(posedge count) begin
		if (reset)
			result.valid <= 1'b0;
		else
			result.valid <= request.valid;
		result.cmd     <= request.cmd;
		result.piece   <= request.candidate;
		result.blocked <= blocked;
	end

	resultFollowsRequest: assert property (@(posedge count) disable iff (reset)
		request.valid |=> (result.valid && !request.valid))
		else $error("request not answered by a single-cycle result");

endmodule

/* design/tetrisPkg.sv */
package tetrisPkg;

	typedef logic [4:0] rowIndex;
	typedef logic [3:0] colIndex;
	typedef logic [2:0] shapeId;

	// Host command codes
	typedef enum logic [2:0] {
		cmdNone    = 3'd0,
		cmdLeft    = 3'd1,
		cmdRight   = 3'd2,
		cmdDrop    = 3'd3,
		cmdRestart = 3'd4
	} cmdCode;

	// Register map
	localparam logic [7:0] regCommand = 8'h00;
	localparam logic [7:0] regStatus  = 8'h04;
	localparam logic [7:0] regRowBase = 8'h40; // row r at base + 4r

	localparam shapeId lastShape = 3'd6;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		shapeId  shape;
		rowIndex row;
		colIndex col;
	} pieceState;

	typedef struct packed {
		logic      valid;
		cmdCode    cmd;
		pieceState current;
		pieceState candidate;
	} moveRequest;

	typedef struct packed {
		logic      valid;
		cmdCode    cmd;
		pieceState piece;
		logic      blocked;
	} moveResult;

	typedef struct packed {
		logic [1:0] dRow;
		logic [1:0] dCol;
	} cellOffset;

	typedef cellOffset [3:0] shapeOffsets;

	// Each nibble is one cell, row offset in the upper two bits
	function automatic shapeOffsets shapeCells(shapeId shape);
		case (shape)
			3'd0: return 16'h0123; // I
			3'd1: return 16'h0145; // O
			3'd2: return 16'h0125; // T
			3'd3: return 16'h1245; // S
			3'd4: return 16'h0156; // Z
			3'd5: return 16'h0124; // L
			3'd6: return 16'h0126; // J
			default: return 16'h0123;
		endcase
	endfunction

endpackage

/* design/tetrisTop.sv */
`timescale 1ns/1ps

module tetrisTop #(
	parameter int boardWidth  = 10,
	parameter int boardHeight = 20
) (
	input  logic             count,
	input  logic             reset,
	input  tetrisPkg::apbReq req,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr
);
	import tetrisPkg::*;

	moveRequest                           request;
	moveResult                            result;
	pieceState                            activePiece;
	rowIndex                              rowSelect;
	logic [boardWidth-1:0]                rowView;
	logic [boardHeight-1:0][boardWidth-1:0] settledRows;
	logic                                 busyDone;
	logic                                 gameOver;
	logic [15:0]                          linesCleared;

	// Port stage, then collision check, then board
	apbKeyPort #(.boardWidth(boardWidth), .boardHeight(boardHeight)) u_apbKeyPort (
		.count(count),
		.reset(reset),
		.req(req),
		.busyDone(busyDone),
		.gameOver(gameOver),
		.linesCleared(linesCleared),
		.activePiece(activePiece),
		.rowView(rowView),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rowSelect(rowSelect),
		.request(request)
	);

	moveCheck #(.boardWidth(boardWidth), .boardHeight(boardHeight)) u_moveCheck (
		.count(count),
		.reset(reset),
		.request(request),
		.settledRows(settledRows),
		.result(result)
	);

	boardUpdate #(.boardWidth(boardWidth), .boardHeight(boardHeight)) u_boardUpdate (
		.count(count),
		.reset(reset),
		.result(result),
		.rowSelect(rowSelect),
		.settledRows(settledRows),
		.activePiece(activePiece),
		.rowView(rowView),
		.busyDone(busyDone),
		.gameOver(gameOver),
		.linesCleared(linesCleared)
	);

endmodule

/* files.f */
+incdir+tests
design/tetrisPkg.sv
design/apbKeyPort.sv
design/moveCheck.sv
design/boardUpdate.sv
design/tetrisTop.sv
tests/tetrisTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tetrisTb -f files.f -o tetrisSim
./obj_dir/tetrisSim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* tests/boardModel.svh */
`ifndef BOARD_MODEL_SVH
`define BOARD_MODEL_SVH

// Mirror of the board, kept in step with every accepted command
logic [boardWidth-1:0] modelRows [boardHeight];
int modelShape;
int modelRow;
int modelCol;
int modelNext;
int modelLines;
int modelLocks;
bit modelOver;

// Spawn cells in table order, row 1 cells listed last
function automatic int offsetRow(int shape, int k);
	case (shape)
		0: return 0;
		1, 3, 4: return (k >= 2) ? 1 : 0;
		default: return (k == 3) ? 1 : 0; // T, L and J
	endcase
endfunction

function automatic int offsetCol(int shape, int k);
	case (shape)
		0: return k;
		1: return k % 2;
		2: return (k == 3) ? 1 : k;
		3: return (k < 2) ? k + 1 : k - 2; // S
		4: return (k < 2) ? k : k - 1;     // Z
		5: return (k == 3) ? 0 : k;
		default: return (k == 3) ? 2 : k;  // J
	endcase
endfunction

// Inside the walls, above the floor and clear of settled cells
function automatic bit pieceFits(int shape, int row, int col);
	bit fits;
	int r;
	int c;
	fits = 1'b1;
	for (int k = 0; k < 4; k++) begin
		r = row + offsetRow(shape, k);
		c = col + offsetCol(shape, k);
		if (c < 0 || c >= boardWidth || r >= boardHeight)
			fits = 1'b0;
		else if (modelRows[r][c])
			fits = 1'b0;
	end
	return fits;
endfunction

// Settled cells plus the active piece
function automatic logic [boardWidth-1:0] expectedRow(int r);
	logic [boardWidth-1:0] bits;
	bits = modelRows[r];
	for (int k = 0; k < 4; k++)
		if (modelRow + offsetRow(modelShape, k) == r)
			bits[modelCol + offsetCol(modelShape, k)] = 1'b1;
	return bits;
endfunction

task automatic spawnNext();
	modelShape = modelNext;
	modelRow   = 0;
	modelCol   = spawnCol;
	modelNext  = (modelNext + 1) % 7;
endtask

// Empty board, shape 0 at the top
task automatic clearModel();
	for (int r = 0; r < boardHeight; r++)
		modelRows[r] = '0;
	modelLines = 0;
	modelLocks = 0;
	modelOver  = 1'b0;
	modelNext  = 0;
	spawnNext();
endtask

task automatic lockPiece();
	int r;
	int row;
	int col;
	for (int k = 0; k < 4; k++) begin
		row = modelRow + offsetRow(modelShape, k);
		col = modelCol + offsetCol(modelShape, k);
		modelRows[row][col] = 1'b1;
	end
	modelLocks++;
	r = boardHeight - 1;
	while (r >= 0) begin
		if (&modelRows[r]) begin
			for (int s = r; s > 0; s--)
				modelRows[s] = modelRows[s - 1];
			modelRows[0] = '0;
			modelLines++; // same row looked at again
		end else begin
			r--;
		end
	end
	// Top row taken or no room for the next shape
	if (modelRows[0] != '0 || !pieceFits(modelNext, 0, spawnCol))
		modelOver = 1'b1;
	else
		spawnNext();
endtask

task automatic applyCommand(int cmd);
	case (cmd)
		1: if (!modelOver && pieceFits(modelShape, modelRow, modelCol - 1))
			modelCol--;
		2: if (!modelOver && pieceFits(modelShape, modelRow, modelCol + 1))
			modelCol++;
		3: if (!modelOver) begin
			if (pieceFits(modelShape, modelRow + 1, modelCol))
				modelRow++;
			else
				lockPiece();
		end
		4: clearModel();
		default: ; // none and unknown codes
	endcase
endtask

`endif

/* tests/tetrisTb.sv */
`timescale 1ns/1ps

module tetrisTb;
	import tetrisPkg::*;

	localparam int boardWidth    = 10;
	localparam int boardHeight   = 20;
	localparam int spawnCol      = boardWidth / 2 - 1;
	localparam int randomCmds    = 300;
	localparam int directedCmds  = 400; // generous bound on the scripted part
	localparam int cmdCycles     = 120; // write, busy polls and 21 reads
	localparam int timeoutCycles = (randomCmds + directedCmds) * cmdCycles;

	logic        count;
	logic        reset;
	apbReq       req;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] rngState;
	int          cycleCount;
	int          statusErrors;
	int          rowErrors;
	int          busErrors;
	int          flowErrors;

	`include "boardModel.svh"

	tetrisTop #(.boardWidth(boardWidth), .boardHeight(boardHeight)) u_tetrisTop (
		.count(count),
		.reset(reset),
		.req(req),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #10 count = ~count;

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	// Setup and access phases, driven on falling edges
	task automatic apbTransfer(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output int waits,
			output logic err);
		@(negedge count);
		req.psel    = 1'b1;
		req.penable = 1'b0;
		req.pwrite  = write;
		req.paddr   = addr;
		req.pwdata  = wdata;
		@(negedge count);
		req.penable = 1'b1;
		waits = 0;
		#5; // mid low phase
		while (!pready) begin
			waits++;
			@(negedge count);
			#5;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge count);
		req.psel    = 1'b0;
		req.penable = 1'b0;
	endtask

	task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
		int   waits;
		logic err;
		apbTransfer(1'b0, addr, 32'd0, data, waits, err);
	endtask

	task automatic waitIdle();
		logic [31:0] status;
		status = 32'd1;
		while (status[0])
			readReg(regStatus, status);
	endtask

	task automatic checkBoard();
		logic [31:0] data;
		logic [31:0] expected;
		expected = {16'(modelLines), 9'd0, 3'(modelShape), 2'd0, modelOver, 1'b0};
		readReg(regStatus, data);
		if (data !== expected) begin
			statusErrors++;
			$display("Error at %0t ns: status expected %h got %h", $time, expected, data);
		end
		for (int r = 0; r < boardHeight; r++) begin
			readReg(8'(int'(regRowBase) + 4 * r), data);
			expected = 32'(expectedRow(r));
			if (data !== expected) begin
				rowErrors++;
				$display("Error at %0t ns: row%0d expected %h got %h", $time, r, expected, data);
			end
		end
	endtask

	// Send, mirror in the model, wait for busy to fall, compare
	task automatic issueCommand(input int cmd);
		int          waits;
		logic        err;
		logic [31:0] unused;
		apbTransfer(1'b1, regCommand, 32'(cmd), unused, waits, err);
		if (err) begin
			busErrors++;
			$display("Command write of code %0d got an error response", cmd);
		end
		applyCommand(cmd);
		waitIdle();
		checkBoard();
	endtask

	task automatic dropToLock();
		int locks;
		locks = modelLocks;
		for (int i = 0; i <= boardHeight && modelLocks == locks && !modelOver; i++)
			issueCommand(cmdDrop);
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge count);
			cycleCount++;
		end
		$display("Timeout after %0d cycles without reaching the end of the tests", cycleCount);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int          pick;
		int          waits;
		logic        err;
		logic [31:0] data;
		count        = 1'b0;
		reset        = 1'b1;
		req          = '0;
		rngState     = 32'd52;
		statusErrors = 0;
		rowErrors    = 0;
		busErrors    = 0;
		flowErrors   = 0;
		clearModel();
		repeat (4) @(posedge count);
		@(negedge count);
		reset = 1'b0;
		checkBoard();

		// I to the left wall, fifth step refused
		repeat (5) issueCommand(cmdLeft);
		dropToLock();
		dropToLock(); // O next to it
		repeat (5) begin
			repeat (4) issueCommand(cmdLeft);
			dropToLock();
		end
		repeat (3) issueCommand(cmdRight); // last one hits the right wall
		dropToLock();
		if (modelLines != 1) begin
			flowErrors++;
			$display("Scripted pieces did not complete exactly one bottom row");
		end

		// Stack at the spawn column until the top fills
		for (int i = 0; i < 30 && !modelOver; i++)
			dropToLock();
		if (!modelOver) begin
			flowErrors++;
			$display("Stacking at the spawn column never ended the game");
		end
		issueCommand(cmdLeft);
		issueCommand(cmdRight);
		issueCommand(cmdDrop);

		// Right right after restart must be held by pready
		apbTransfer(1'b1, regCommand, 32'(cmdRestart), data, waits, err);
		apbTransfer(1'b1, regCommand, 32'(cmdRight), data, waits, err);
		if (waits == 0) begin
			busErrors++;
			$display("Command written during restart was not held off by pready");
		end
		applyCommand(cmdRestart);
		applyCommand(cmdRight);
		waitIdle();
		checkBoard();

		apbTransfer(1'b1, regStatus, 32'd0, data, waits, err);
		if (!err) begin
			busErrors++;
			$display("Write to the status register was not refused with pslverr");
		end
		issueCommand(7);
		issueCommand(cmdNone);

		for (int n = 0; n < randomCmds; n++) begin
			pick = int'(nextRandom() >> 8) % 100;
			if (pick < 30)
				issueCommand(cmdLeft);
			else if (pick < 60)
				issueCommand(cmdRight);
			else if (pick < 95)
				issueCommand(cmdDrop);
			else
				issueCommand(cmdRestart);
		end

		$display("Checks finished with %0d status, %0d row, %0d bus and %0d sequence errors",
			statusErrors, rowErrors, busErrors, flowErrors);
		if (statusErrors + rowErrors + busErrors + flowErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
